// ==== compile.f ====
hdl/mem_pkg.sv
hdl/lsu_pkg.sv
hdl/dp_ram.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/mem_subsystem.sv
test/mem_subsystem_sva.sv
test/mem_subsystem_tb.sv

// ==== hdl/dp_ram.sv ====
`timescale 1ns/1ps

module dp_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           a_valid_i,
    output logic                           a_ready_o,
    input  logic [ADDR_WIDTH-1:0]          a_addr_i,
    input  logic [mem_pkg::word_width-1:0] a_wdata_i,
    input  logic [mem_pkg::be_width-1:0]   a_we_i,
    output logic [mem_pkg::word_width-1:0] a_rdata_o,
    input  logic                           b_valid_i,
    output logic                           b_ready_o,
    input  logic [ADDR_WIDTH-1:0]          b_addr_i,
    input  logic [mem_pkg::word_width-1:0] b_wdata_i,
    input  logic [mem_pkg::be_width-1:0]   b_we_i,
    output logic [mem_pkg::word_width-1:0] b_rdata_o,
    input  logic                           rst_i
);

    import mem_pkg::*;

    localparam int depth = 2 ** (ADDR_WIDTH - 2);

    logic [word_width-1:0] mem [depth];
    logic [ADDR_WIDTH-3:0] a_idx;
    logic [ADDR_WIDTH-3:0] b_idx;
    logic                  a_acc;
    logic                  b_acc;

    assign a_idx = a_addr_i[ADDR_WIDTH-1:2]; // byte offset bits are ignored.
    assign b_idx = b_addr_i[ADDR_WIDTH-1:2];
    assign a_acc = a_valid_i && !a_ready_o;
    assign b_acc = b_valid_i && !b_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            a_ready_o <= 1'b0;
            b_ready_o <= 1'b0;
        end else begin
            a_ready_o <= a_acc; // a held valid is taken every other cycle.
            b_ready_o <= b_acc;
        end
    end

    // read data shows the word as it was before this access wrote it.
    always_ff @(posedge clk) begin
        if (a_acc) a_rdata_o <= mem[a_idx];
        if (b_acc) b_rdata_o <= mem[b_idx];
    end

    always @(posedge clk) begin
        for (int i = 0; i < be_width; i++) begin
            if (a_acc && a_we_i[i]) mem[a_idx][8*i +: 8] <= a_wdata_i[8*i +: 8];
        end
        for (int i = 0; i < be_width; i++) begin
            if (b_acc && b_we_i[i]) mem[b_idx][8*i +: 8] <= b_wdata_i[8*i +: 8];
        end // port B is assigned last, so its bytes win on a collision.
    end

    function automatic logic [word_width-1:0] read_word(input logic [ADDR_WIDTH-1:0] byte_addr);
        return mem[byte_addr[ADDR_WIDTH-1:2]];
    endfunction

    task automatic write_word(input logic [ADDR_WIDTH-1:0] byte_addr,
                              input logic [word_width-1:0] data);
        mem[byte_addr[ADDR_WIDTH-1:2]] = data;
    endtask

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           fetch_start_i,
    input  logic [ADDR_WIDTH-1:0]          fetch_pc_i,
    input  logic                           fetch_stall_i,
    output logic                           mem_valid_o,
    input  logic                           mem_ready_i,
    output logic [ADDR_WIDTH-1:0]          mem_addr_o,
    input  logic [mem_pkg::word_width-1:0] mem_rdata_i,
    output logic                           instr_valid_o,
    output logic [mem_pkg::word_width-1:0] instr_o,
    output logic [ADDR_WIDTH-1:0]          instr_pc_o
);

    import mem_pkg::*;

    fetch_state_t          state;
    logic [ADDR_WIDTH-1:0] pc;     // next address to request.
    logic [ADDR_WIDTH-1:0] req_pc; // address of the request in flight.
    logic [ADDR_WIDTH-1:0] hold_pc;
    logic [word_width-1:0] hold_instr;
    logic                  inflight;
    logic                  accept;
    logic                  take;

    // no request goes out in the start cycle, so nothing stale can follow a restart.
    assign mem_valid_o = (state != fetch_idle) && !fetch_stall_i && !fetch_start_i;
    assign mem_addr_o  = pc;
    assign accept      = mem_valid_o && !mem_ready_i;
    assign take        = (state == fetch_run) && inflight && mem_ready_i;

    assign instr_valid_o = !fetch_stall_i && !fetch_start_i && (take || state == fetch_hold);
    assign instr_o       = (state == fetch_hold) ? hold_instr : mem_rdata_i;
    assign instr_pc_o    = (state == fetch_hold) ? hold_pc : req_pc;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= fetch_idle;
            inflight <= 1'b0;
        end else if (fetch_start_i) begin
            state    <= fetch_run;
            inflight <= 1'b0; // drops any response still on its way.
        end else begin
            if (accept) inflight <= 1'b1;
            else if (mem_ready_i) inflight <= 1'b0;
            case (state)
                fetch_run:  if (take && fetch_stall_i) state <= fetch_hold;
                fetch_hold: if (!fetch_stall_i) state <= fetch_run;
                default:    state <= fetch_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start_i) begin
            pc <= {fetch_pc_i[ADDR_WIDTH-1:2], 2'b00};
        end else if (accept) begin
            req_pc <= pc;
            pc     <= pc + ADDR_WIDTH'(4);
        end
        if (take && fetch_stall_i) begin
            hold_instr <= mem_rdata_i;
            hold_pc    <= req_pc;
        end
    end

endmodule

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           lsu_req_i,
    input  lsu_pkg::mem_op_t               lsu_op_i,
    input  logic [ADDR_WIDTH-1:0]          lsu_addr_i,
    input  logic [mem_pkg::word_width-1:0] lsu_wdata_i,
    output logic                           lsu_done_o,
    output logic [mem_pkg::word_width-1:0] lsu_rdata_o,
    output logic                           lsu_err_o,
    output logic                           mem_valid_o,
    input  logic                           mem_ready_i,
    output logic [ADDR_WIDTH-1:0]          mem_addr_o,
    output logic [mem_pkg::word_width-1:0] mem_wdata_o,
    output logic [mem_pkg::be_width-1:0]   mem_we_o,
    input  logic [mem_pkg::word_width-1:0] mem_rdata_i
);

    import mem_pkg::*;
    import lsu_pkg::*;

    lsu_state_t            state;
    mem_op_t               op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [word_width-1:0] wdata_q;
    logic [1:0]            off;
    logic                  misaligned;
    logic [be_width-1:0]   be;
    logic [7:0]            rd_byte;
    logic [15:0]           rd_half;
    logic [word_width-1:0] load_val;
    logic                  start;

    assign start = (state == lsu_idle) && lsu_req_i;

    // the check looks at the incoming request so an error answers one cycle later.
    always_comb begin
        case (lsu_op_i)
            op_lh, op_lhu, op_sh: misaligned = lsu_addr_i[0];
            op_lw, op_sw:         misaligned = lsu_addr_i[1:0] != 2'b00;
            default:              misaligned = 1'b0;
        endcase
    end

    assign off = addr_q[1:0];

    always_comb begin
        be          = '0;
        mem_wdata_o = wdata_q;
        case (op_q)
            op_sb: begin
                be          = 4'b0001 << off;
                mem_wdata_o = {4{wdata_q[7:0]}};
            end
            op_sh: begin
                be          = 4'b0011 << {off[1], 1'b0};
                mem_wdata_o = {2{wdata_q[15:0]}};
            end
            op_sw: be = 4'b1111;
            default: be = '0; // loads never write.
        endcase
    end

    assign mem_valid_o = (state != lsu_idle);
    assign mem_addr_o  = addr_q;
    assign mem_we_o    = (state != lsu_idle) ? be : '0;

    assign rd_byte = mem_rdata_i[8*off +: 8];
    assign rd_half = off[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    always_comb begin
        case (op_q)
            op_lb:   load_val = {{(word_width-8){rd_byte[7]}}, rd_byte};
            op_lbu:  load_val = {{(word_width-8){1'b0}}, rd_byte};
            op_lh:   load_val = {{(word_width-16){rd_half[15]}}, rd_half};
            op_lhu:  load_val = {{(word_width-16){1'b0}}, rd_half};
            op_lw:   load_val = mem_rdata_i;
            default: load_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= lsu_idle;
            lsu_done_o <= 1'b0;
            lsu_err_o  <= 1'b0;
        end else begin
            lsu_done_o <= 1'b0;
            lsu_err_o  <= 1'b0;
            case (state)
                lsu_idle: begin
                    if (lsu_req_i && misaligned) begin
                        lsu_done_o <= 1'b1;
                        lsu_err_o  <= 1'b1;
                    end else if (lsu_req_i) begin
                        state <= lsu_req;
                    end
                end
                lsu_req:  if (!mem_ready_i) state <= lsu_wait; // memory takes it here.
                lsu_wait: begin
                    if (mem_ready_i) begin
                        state      <= lsu_idle;
                        lsu_done_o <= 1'b1;
                    end
                end
                default:  state <= lsu_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q    <= lsu_op_i;
            addr_q  <= lsu_addr_i;
            wdata_q <= lsu_wdata_i;
        end
        if (start && misaligned) lsu_rdata_o <= '0;
        else if (state == lsu_wait && mem_ready_i) lsu_rdata_o <= load_val;
    end

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

    // loads keep their RV32I funct3 code and stores take the free codes.
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_sb  = 3'd3,
        op_lbu = 3'd4,
        op_lhu = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_t;

    typedef enum logic [1:0] {
        lsu_idle,
        lsu_req,  // valid is up and the memory has not yet accepted.
        lsu_wait  // accepted, waiting for the ready pulse.
    } lsu_state_t;

endpackage

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    localparam int word_width = 32;
    localparam int be_width   = word_width / 8; // one enable per byte lane.

    // fetch_hold keeps a word that came back while the consumer was stalled.
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_run,
        fetch_hold
    } fetch_state_t;

endpackage

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           fetch_start_i,
    input  logic [ADDR_WIDTH-1:0]          fetch_pc_i,
    input  logic                           fetch_stall_i,
    output logic                           instr_valid_o,
    output logic [mem_pkg::word_width-1:0] instr_o,
    output logic [ADDR_WIDTH-1:0]          instr_pc_o,
    input  logic                           lsu_req_i,
    input  lsu_pkg::mem_op_t               lsu_op_i,
    input  logic [ADDR_WIDTH-1:0]          lsu_addr_i,
    input  logic [mem_pkg::word_width-1:0] lsu_wdata_i,
    output logic                           lsu_done_o,
    output logic [mem_pkg::word_width-1:0] lsu_rdata_o,
    output logic                           lsu_err_o
);

    import mem_pkg::*;

    logic                  a_valid;
    logic                  a_ready;
    logic [ADDR_WIDTH-1:0] a_addr;
    logic [word_width-1:0] a_rdata;
    logic                  b_valid;
    logic                  b_ready;
    logic [ADDR_WIDTH-1:0] b_addr;
    logic [word_width-1:0] b_wdata;
    logic [be_width-1:0]   b_we;
    logic [word_width-1:0] b_rdata;

    fetch_unit #(.ADDR_WIDTH(ADDR_WIDTH)) fetch0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_start_i (fetch_start_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_stall_i (fetch_stall_i),
        .mem_valid_o   (a_valid),
        .mem_ready_i   (a_ready),
        .mem_addr_o    (a_addr),
        .mem_rdata_i   (a_rdata),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o)
    );

    load_store_unit #(.ADDR_WIDTH(ADDR_WIDTH)) lsu0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .lsu_req_i   (lsu_req_i),
        .lsu_op_i    (lsu_op_i),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .lsu_done_o  (lsu_done_o),
        .lsu_rdata_o (lsu_rdata_o),
        .lsu_err_o   (lsu_err_o),
        .mem_valid_o (b_valid),
        .mem_ready_i (b_ready),
        .mem_addr_o  (b_addr),
        .mem_wdata_o (b_wdata),
        .mem_we_o    (b_we),
        .mem_rdata_i (b_rdata)
    );

    // port A is read only because the fetcher never writes.
    dp_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ram0 (
        .clk       (clk),
        .a_valid_i (a_valid),
        .a_ready_o (a_ready),
        .a_addr_i  (a_addr),
        .a_wdata_i ('0),
        .a_we_i    ('0),
        .a_rdata_o (a_rdata),
        .b_valid_i (b_valid),
        .b_ready_o (b_ready),
        .b_addr_i  (b_addr),
        .b_wdata_i (b_wdata),
        .b_we_i    (b_we),
        .b_rdata_o (b_rdata),
        .rst_i     (rst_i)
    );

endmodule

// ==== test/mem_subsystem_sva.sv ====
`timescale 1ns/1ps

module mem_subsystem_sva (
    input logic                         clk,
    input logic                         rst_i,
    input logic                         ready_a_i,
    input logic                         ready_b_i,
    input logic                         start_i,
    input logic                         misaligned_i,
    input logic                         done_i,
    input logic                         err_i,
    input logic [mem_pkg::be_width-1:0] we_i,
    input lsu_pkg::mem_op_t             op_i,
    input lsu_pkg::lsu_state_t          state_i
);

    import lsu_pkg::*;

    logic is_load;
    int   fail_count = 0; // number of failed assertions in this instance.

    assign is_load = op_i inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};

    // ready is a single-cycle pulse on both ports.
    assert property (@(posedge clk) disable iff (rst_i) ready_a_i |=> !ready_a_i)
        else begin
            fail_count++;
            $error("port A ready high for two cycles");
        end
    assert property (@(posedge clk) disable iff (rst_i) ready_b_i |=> !ready_b_i)
        else begin
            fail_count++;
            $error("port B ready high for two cycles");
        end

    assert property (@(posedge clk) disable iff (rst_i)
        start_i && !misaligned_i |=> !done_i ##1 !done_i ##1 done_i)
        else begin
            fail_count++;
            $error("lsu_done_o not exactly 3 cycles after an aligned request");
        end

    assert property (@(posedge clk) disable iff (rst_i)
        (state_i != lsu_idle) && is_load |-> we_i == '0)
        else begin
            fail_count++;
            $error("byte enables set during a load");
        end

    assert property (@(posedge clk) disable iff (rst_i) err_i |-> done_i)
        else begin
            fail_count++;
            $error("lsu_err_o without lsu_done_o");
        end

endmodule

// ==== test/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

    import mem_pkg::*;
    import lsu_pkg::*;

    localparam int aw             = 12;
    localparam int timeout_cycles = 50;

    logic                  clk = 1'b0;
    logic                  rst_i;
    logic                  fetch_start_i;
    logic [aw-1:0]         fetch_pc_i;
    logic                  fetch_stall_i;
    logic                  instr_valid_o;
    logic [word_width-1:0] instr_o;
    logic [aw-1:0]         instr_pc_o;
    logic                  lsu_req_i;
    mem_op_t               lsu_op_i;
    logic [aw-1:0]         lsu_addr_i;
    logic [word_width-1:0] lsu_wdata_i;
    logic                  lsu_done_o;
    logic [word_width-1:0] lsu_rdata_o;
    logic                  lsu_err_o;
    logic [7:0]            model [2**aw]; // little-endian byte image of the memory.
    int                    error_count = 0;

    mem_subsystem #(.ADDR_WIDTH(aw)) dut0 (.*);

    bind dp_ram mem_subsystem_sva ram_sva (
        .clk(clk), .rst_i(rst_i), .ready_a_i(a_ready_o), .ready_b_i(b_ready_o),
        .start_i(1'b0), .misaligned_i(1'b0), .done_i(1'b0), .err_i(1'b0),
        .we_i('0), .op_i(lsu_pkg::op_lb), .state_i(lsu_pkg::lsu_idle));
    bind load_store_unit mem_subsystem_sva lsu_sva (
        .clk(clk), .rst_i(rst_i), .ready_a_i(1'b0), .ready_b_i(1'b0),
        .start_i(start), .misaligned_i(misaligned), .done_i(lsu_done_o), .err_i(lsu_err_o),
        .we_i(mem_we_o), .op_i(op_q), .state_i(state));

    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (dut0.ram0.ram_sva.fail_count + dut0.lsu0.lsu_sva.fail_count != 0) begin
            fail_run("a bound assertion on the memory or load/store unit failed");
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            fail_run($sformatf("Error at %0t ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] model_word(input logic [aw-1:0] a);
        logic [aw-1:0] base;
        base = {a[aw-1:2], 2'b00};
        return {model[base+3], model[base+2], model[base+1], model[base]};
    endfunction

    function automatic logic [31:0] expected_load(input mem_op_t op, input logic [aw-1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = model[a];
        h = {model[a+1], model[a]};
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            op_lw:   return model_word(a);
            default: return 32'h0; // stores return zero.
        endcase
    endfunction

    task automatic update_model(input mem_op_t op, input logic [aw-1:0] a, input logic [31:0] d);
        case (op)
            op_sb: model[a] = d[7:0];
            op_sh: begin
                model[a]   = d[7:0];
                model[a+1] = d[15:8];
            end
            op_sw: for (int i = 0; i < 4; i++) model[a+i] = d[8*i +: 8];
            default: ;
        endcase
    endtask

    task automatic preload_word(input logic [aw-1:0] a, input logic [31:0] w);
        dut0.ram0.write_word(a, w);
        for (int i = 0; i < 4; i++) model[a+i] = w[8*i +: 8];
    endtask

    task automatic compare_backdoor(input logic [aw-1:0] a);
        check_equal(dut0.ram0.read_word(a), model_word(a), "backdoor word");
    endtask

    task automatic lsu_access(input mem_op_t op, input logic [aw-1:0] a, input logic [31:0] d);
        logic        bad;
        logic [31:0] exp;
        int          cycles;
        // halfwords need an even address and words a multiple of 4.
        bad = ((op == op_lh || op == op_lhu || op == op_sh) && a[0])
            || ((op == op_lw || op == op_sw) && a[1:0] != 2'b00);
        exp = expected_load(op, a);
        @(posedge clk);
        lsu_req_i   <= 1'b1;
        lsu_op_i    <= op;
        lsu_addr_i  <= a;
        lsu_wdata_i <= d;
        @(posedge clk);
        lsu_req_i <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles) fail_run("timeout while waiting for lsu_done_o");
        end while (!lsu_done_o);
        check_equal(cycles, bad ? 1 : 3, "lsu_done_o latency");
        check_equal(lsu_err_o, bad, "lsu_err_o");
        if (!bad) begin
            check_equal(lsu_rdata_o, exp, "lsu_rdata_o");
            update_model(op, a, d);
        end
    endtask

    task automatic run_fetch(input logic [aw-1:0] pc0, input int count, input bit stalls);
        logic [aw-1:0] exp_pc;
        int            got;
        int            waited;
        exp_pc = pc0;
        got    = 0;
        waited = 0;
        @(posedge clk);
        fetch_start_i <= 1'b1;
        fetch_pc_i    <= pc0;
        @(posedge clk);
        fetch_start_i <= 1'b0;
        while (got < count) begin
            @(negedge clk);
            waited++;
            if (instr_valid_o) begin
                check_equal(fetch_stall_i, 1'b0, "instr_valid_o while stalled");
                if (got == 0 && !stalls) check_equal(waited, 2, "first fetch latency");
                check_equal(instr_pc_o, exp_pc, "instr_pc_o");
                check_equal(instr_o, model_word(exp_pc), "instr_o");
                exp_pc += 4;
                got++;
                waited = 0;
            end else if (waited > timeout_cycles) begin
                fail_run("timeout while waiting for instr_valid_o");
            end
            @(posedge clk);
            if (stalls) fetch_stall_i <= (($urandom % 3) == 0);
        end
        fetch_stall_i <= 1'b0;
    endtask

    task automatic stores_then_loads();
        for (int i = 0; i < 8; i++) lsu_access(op_sw, aw'(12'h100 + 4 * i), $urandom);
        for (int i = 0; i < 8; i++) begin
            lsu_access(op_lw, aw'(12'h100 + 4 * i), 32'h0);
            compare_backdoor(aw'(12'h100 + 4 * i));
        end
    endtask

    task automatic sub_word_accesses();
        for (int off = 0; off < 4; off++) begin
            lsu_access(op_sb, aw'(12'h200 + off), $urandom);
            compare_backdoor(12'h200);
        end
        for (int off = 0; off < 4; off += 2) begin
            lsu_access(op_sh, aw'(12'h204 + off), $urandom);
            compare_backdoor(12'h204);
        end
        lsu_access(op_sw, 12'h208, 32'h80ff_7f01); // both signs in bytes and halfwords.
        for (int off = 0; off < 12; off++) begin
            lsu_access(op_lb, aw'(12'h200 + off), 32'h0);
            lsu_access(op_lbu, aw'(12'h200 + off), 32'h0);
        end
        for (int off = 0; off < 12; off += 2) begin
            lsu_access(op_lh, aw'(12'h200 + off), 32'h0);
            lsu_access(op_lhu, aw'(12'h200 + off), 32'h0);
        end
    endtask

    task automatic misaligned_requests();
        lsu_access(op_lh, 12'h301, 32'h0);
        lsu_access(op_lw, 12'h302, 32'h0);
        lsu_access(op_sw, 12'h301, $urandom);
        lsu_access(op_sw, 12'h306, $urandom);
        compare_backdoor(12'h300);
        compare_backdoor(12'h304);
    endtask

    task automatic fetch_beside_stores();
        logic [31:0] data [8];
        for (int i = 0; i < 8; i++) data[i] = $urandom;
        // the stores land 32 words ahead, long before the fetcher gets there.
        fork
            run_fetch(12'h800, 48, 1'b0);
            for (int i = 0; i < 8; i++) begin
                if (i % 2 == 1) begin
                    lsu_access(op_sb, aw'(12'h880 + 4 * i + 1), data[i]);
                end else begin
                    lsu_access(op_sw, aw'(12'h880 + 4 * i), data[i]);
                end
            end
        join
    endtask

    initial begin
        void'($urandom(31));
        rst_i         = 1'b1;
        fetch_start_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_stall_i = 1'b0;
        lsu_req_i     = 1'b0;
        lsu_op_i      = op_lb;
        lsu_addr_i    = '0;
        lsu_wdata_i   = '0;
        for (int w = 0; w < 2 ** (aw - 2); w++) begin
            preload_word(aw'(4 * w), {4'h5, aw'(4 * w), 4'ha, ~aw'(4 * w)});
        end
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        stores_then_loads();
        sub_word_accesses();
        misaligned_requests();
        @(negedge clk);
        for (int i = 0; i < 24; i++) preload_word(aw'(12'h400 + 4 * i), $urandom);
        run_fetch(12'h400, 24, 1'b0);
        run_fetch(12'h400, 24, 1'b1);
        fetch_beside_stores();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
